// File: project.f
+incdir+verification
logic/rv_m_pkg.sv
logic/muldiv_cfg_pkg.sv
logic/operand_prep.sv
logic/mul_pipe.sv
logic/div_restoring.sv
logic/muldiv_unit.sv
verification/muldiv_tb.sv

// File: Makefile
# Verilator build and run of the MULDIV unit testbench.

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: verification/muldiv_model.svh
// Reference model of the RV32 M operations, written from the ISA rules.
// Included inside the testbench module; also holds the operand LCG.
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// ****************************************
// Random numbers.
// ****************************************
// Plain 32-bit LCG, modulo 2^32. Low bits are weak.
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// True for x/0 and for -2^31 / -1 on a signed divide or remainder.
function automatic logic is_special(input rv_m_pkg::funct3_e f3,
                                    input logic [rv_m_pkg::DATA_WIDTH-1:0] a,
                                    input logic [rv_m_pkg::DATA_WIDTH-1:0] b);
    logic is_div;
    logic ovf;
    is_div = f3 inside {rv_m_pkg::DIV, rv_m_pkg::DIVU, rv_m_pkg::REM, rv_m_pkg::REMU};
    ovf    = (f3 inside {rv_m_pkg::DIV, rv_m_pkg::REM}) &&
             (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    return is_div && ((b == 32'd0) || ovf);
endfunction

// ****************************************
// Result of one operation.
// ****************************************
function automatic logic [rv_m_pkg::DATA_WIDTH-1:0] model_result(
        input rv_m_pkg::funct3_e f3,
        input logic [rv_m_pkg::DATA_WIDTH-1:0] a,
        input logic [rv_m_pkg::DATA_WIDTH-1:0] b);
    longint      sa;   // Sign-extended operands.
    longint      sb;
    longint      ua;   // Zero-extended operands.
    longint      ub;
    logic [63:0] prod;
    int          ia;
    int          ib;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'({32'd0, a});
    ub = longint'({32'd0, b});
    ia = $signed(a);
    ib = $signed(b);
    case (f3)
        rv_m_pkg::MUL: begin
            prod = sa * sb;
            return prod[31:0];
        end
        rv_m_pkg::MULH: begin
            prod = sa * sb;
            return prod[63:32];
        end
        rv_m_pkg::MULHSU: begin
            prod = sa * ub; // Fits in 64 signed bits.
            return prod[63:32];
        end
        rv_m_pkg::MULHU: begin
            prod = ua * ub; // Wraps, but the bits are right modulo 2^64.
            return prod[63:32];
        end
        rv_m_pkg::DIV: begin
            if (b == 32'd0) return 32'hffff_ffff;
            if (is_special(f3, a, b)) return a;
            return ia / ib;       // Truncates toward zero.
        end
        rv_m_pkg::REM: begin
            if (b == 32'd0) return a;
            if (is_special(f3, a, b)) return 32'd0;
            return ia % ib;       // Sign of the dividend.
        end
        rv_m_pkg::DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
        rv_m_pkg::REMU: return (b == 32'd0) ? a : a % b;
        default: return 32'd0;
    endcase
endfunction

`endif

// File: verification/muldiv_tb.sv
// Self-checking testbench for muldiv_unit with random operands from a fixed-seed LCG.
// Inputs change on the falling edge; outputs are read there or 1 ns after it.
`timescale 1ns/1ns

module muldiv_tb;

    localparam int W          = rv_m_pkg::DATA_WIDTH;
    localparam int CLK_PERIOD = 100;                      // ns.
    localparam int RST_CYCLES = 16;
    localparam int N_MUL      = 32;                       // Random multiplies.
    localparam int N_DIV      = 32;                       // Random divides.
    localparam int N_OPS      = N_MUL + N_DIV + 6 + 8 + 2; // Held start counts as two.
    localparam int WAIT_MAX   = W + 8;                    // Busy limit per operation.

    logic              clk;
    logic              rstLow;
    logic [W-1:0]      rs1_i;
    logic [W-1:0]      rs2_i;
    rv_m_pkg::funct3_e funct3_i;
    logic              start_i;
    logic [W-1:0]      c_o;
    logic              busy_o;

    logic [31:0]       seed;   // LCG state.
    int                checks;
    int                errors;

    `include "muldiv_model.svh"

    muldiv_unit dut0 (
        .clk      (clk),
        .rstLow   (rstLow),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .funct3_i (funct3_i),
        .start_i  (start_i),
        .c_o      (c_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a hung run; budget is the op count times the longest op.
    initial begin
        #((N_OPS * (W + 4) + RST_CYCLES + 200) * CLK_PERIOD);
        $display("watchdog: simulation ran past its time limit");
        $display("TB FAILED");
        $finish;
    end

    // ****************************************
    // Helpers.
    // ****************************************
    // High halves of two LCG steps.
    task automatic rand_word(output logic [W-1:0] w);
        logic [31:0] s1;
        seed = lcg_step(seed);
        s1   = seed;
        seed = lcg_step(seed);
        w    = {s1[31:16], seed[31:16]};
    endtask

    // Expected busy cycles of the unit, counting the start cycle.
    function automatic int op_cycles(input rv_m_pkg::funct3_e f3,
                                     input logic [W-1:0] a, input logic [W-1:0] b);
        if (f3 inside {rv_m_pkg::MUL, rv_m_pkg::MULH, rv_m_pkg::MULHSU, rv_m_pkg::MULHU})
            return muldiv_cfg_pkg::MUL_LATENCY;
        if (is_special(f3, a, b))
            return 0;                                     // Answered at once.
        return W + 1;
    endfunction

    task automatic check_value(input logic [W-1:0] got, input logic [W-1:0] exp,
                               input rv_m_pkg::funct3_e f3,
                               input logic [W-1:0] a, input logic [W-1:0] b);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch c_o: got %h expected %h (%s rs1 %h rs2 %h)",
                     got, exp, f3.name(), a, b);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input rv_m_pkg::funct3_e f3);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("busy_o was high for %0d cycles instead of %0d (%s)",
                     got, exp, f3.name());
        end
    endtask

    // One operation; hold keeps start_i high for extra falling edges.
    task automatic run_op(input rv_m_pkg::funct3_e f3, input logic [W-1:0] a,
                          input logic [W-1:0] b, input int exp_cycles, input int hold);
        int           busy_cnt;
        int           n;
        logic [W-1:0] exp_c;
        exp_c    = model_result(f3, a, b);
        busy_cnt = 0;
        n        = 0;
        rs1_i    = a;                                      // Caller stands on a falling edge.
        rs2_i    = b;
        funct3_i = f3;
        start_i  = 1'b1;
        #1;
        if (busy_o) busy_cnt++;                            // Start cycle.
        if (exp_cycles == 0) check_value(c_o, exp_c, f3, a, b);
        do begin
            @(negedge clk);
            n++;
            if (busy_o) busy_cnt++;
            if (n > hold) start_i = 1'b0;
        end while ((busy_o || n <= hold) && n < WAIT_MAX + hold);
        checks++;
        assert (!busy_o) else begin
            errors++;
            $display("busy_o did not fall within %0d cycles (%s)", n, f3.name());
        end
        check_cycles(busy_cnt, exp_cycles, f3);
        check_value(c_o, exp_c, f3, a, b);
        start_i = 1'b0;
        @(negedge clk);                                    // Start low for a full cycle.
    endtask

    task automatic report_test(input int num, input string name, input int ops, input int err0);
        $display("test %0d %s: %0d ops, %0d errors", num, name, ops, errors - err0);
    endtask

    // ****************************************
    // Test sequence.
    // ****************************************
    initial begin
        int                err0;
        logic [W-1:0]      a;
        logic [W-1:0]      b;
        logic [W-1:0]      r;
        rv_m_pkg::funct3_e f3;
        rstLow   = 1'b0;
        rs1_i    = '0;
        rs2_i    = '0;
        funct3_i = rv_m_pkg::MUL;
        start_i  = 1'b0;
        seed     = 32'd20;
        checks   = 0;
        errors   = 0;
        repeat (RST_CYCLES) @(negedge clk);
        rstLow = 1'b1;

        err0 = errors;                                     // Idle after reset.
        repeat (4) begin
            @(negedge clk);
            checks++;
            assert (busy_o === 1'b0) else begin
                errors++;
                $display("mismatch busy_o: got %h expected %h after reset", busy_o, 1'b0);
            end
        end
        report_test(1, "idle after reset", 0, err0);

        err0 = errors;
        for (int i = 0; i < N_MUL; i++) begin
            rand_word(a);
            rand_word(b);
            rand_word(r);
            f3 = rv_m_pkg::funct3_e'({1'b0, r[1:0]});
            run_op(f3, a, b, op_cycles(f3, a, b), 0);
        end
        report_test(2, "random multiply", N_MUL, err0);

        err0 = errors;
        for (int i = 0; i < N_DIV; i++) begin
            rand_word(a);
            rand_word(b);
            rand_word(r);
            b  = b >> r[8:4];                              // Spread the quotient sizes.
            f3 = rv_m_pkg::funct3_e'({1'b1, r[1:0]});
            run_op(f3, a, b, op_cycles(f3, a, b), 0);
        end
        report_test(3, "random divide", N_DIV, err0);

        err0 = errors;
        rand_word(a);
        run_op(rv_m_pkg::DIV, a, '0, 0, 0);
        run_op(rv_m_pkg::DIVU, a, '0, 0, 0);
        run_op(rv_m_pkg::REM, a, '0, 0, 0);
        run_op(rv_m_pkg::REMU, a, '0, 0, 0);
        run_op(rv_m_pkg::DIV, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        run_op(rv_m_pkg::REM, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        report_test(4, "divide by zero and overflow", 6, err0);

        err0 = errors;
        rand_word(a);
        rand_word(b);
        a = a | 32'd1;                                     // Never -2^31, never x/0.
        b = b | 32'd1;
        run_op(rv_m_pkg::DIV, a, b, W + 1, 0);
        run_op(rv_m_pkg::REM, a, b, 0, 0);
        run_op(rv_m_pkg::DIVU, a, b, W + 1, 0);
        run_op(rv_m_pkg::REMU, a, b, 0, 0);
        run_op(rv_m_pkg::DIV, a, b, W + 1, 0);
        run_op(rv_m_pkg::REM, a ^ 32'd2, b, W + 1, 0);     // Changed dividend.
        run_op(rv_m_pkg::DIVU, a, b, W + 1, 0);
        run_op(rv_m_pkg::REMU, a, b ^ 32'd2, W + 1, 0);    // Changed divisor.
        report_test(5, "remainder reuse", 8, err0);

        err0 = errors;
        rand_word(a);
        rand_word(b);
        a = a | 32'd1;
        b = b | 32'd1;
        run_op(rv_m_pkg::DIV, a, b, W + 1, 2 * (W + 4));
        report_test(6, "start held high", 1, err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: logic/muldiv_unit.sv
// RV32 M-extension unit. The core polls busy_o after a start strobe and holds
// rs1, rs2 and funct3 until busy_o is low; c_o is combinational from them.
// A new start needs start_i low for at least one cycle in between.
`timescale 1ns/1ns

module muldiv_unit (
    input  logic                            clk,
    input  logic                            rstLow,
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] rs1_i,    // Multiplicand or dividend.
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] rs2_i,    // Multiplier or divisor.
    input  rv_m_pkg::funct3_e               funct3_i, // Operation select.
    input  logic                            start_i,  // Start request, level or pulse.
    output logic [rv_m_pkg::DATA_WIDTH-1:0] c_o,      // Result.
    output logic                            busy_o    // Core must stall while high.
);

    logic [rv_m_pkg::DATA_WIDTH-1:0]   a_mag;      // Operand magnitudes.
    logic [rv_m_pkg::DATA_WIDTH-1:0]   b_mag;
    logic                              a_signed;
    logic                              b_signed;
    logic                              div_zero;
    logic                              div_ovf;
    logic [2*rv_m_pkg::DATA_WIDTH-1:0] product;
    logic                              mul_done;
    logic [rv_m_pkg::DATA_WIDTH-1:0]   quotient;   // Unsigned divider results.
    logic [rv_m_pkg::DATA_WIDTH-1:0]   remainder;
    logic                              div_busy;

    logic                              start_q;    // start_i one cycle ago.
    logic                              start_acc;  // Accepted start, one per operation.
    logic                              is_div;
    logic                              special;    // x/0 or signed overflow.
    logic                              reuse;      // Remainder already computed.
    logic                              mul_load;
    logic                              div_start;
    logic                              mul_pend_q; // Product still on its way.

    logic [rv_m_pkg::DATA_WIDTH-1:0]   prev_a_q;   // Operands of the last started op.
    logic [rv_m_pkg::DATA_WIDTH-1:0]   prev_b_q;
    rv_m_pkg::funct3_e                 prev_f3_q;

    logic [rv_m_pkg::DATA_WIDTH-1:0]   q_res;      // Final quotient.
    logic [rv_m_pkg::DATA_WIDTH-1:0]   r_res;      // Final remainder.

    // ****************************************
    // Sub-blocks.
    // ****************************************
    operand_prep u_prep (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .funct3_i   (funct3_i),
        .a_mag_o    (a_mag),
        .b_mag_o    (b_mag),
        .a_signed_o (a_signed),
        .b_signed_o (b_signed),
        .div_zero_o (div_zero),
        .div_ovf_o  (div_ovf)
    );

    mul_pipe u_mul (
        .clk        (clk),
        .rstLow     (rstLow),
        .load_i     (mul_load),
        .a_i        (rs1_i),
        .b_i        (rs2_i),
        .a_signed_i (a_signed),
        .b_signed_i (b_signed),
        .product_o  (product),
        .done_o     (mul_done)
    );

    div_restoring u_div (
        .clk         (clk),
        .rstLow      (rstLow),
        .start_i     (div_start),
        .dividend_i  (a_mag),
        .divisor_i   (b_mag),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .busy_o      (div_busy)
    );

    // ****************************************
    // Start control.
    // ****************************************
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            start_q    <= 1'b0;
            mul_pend_q <= 1'b0;
        end else begin
            start_q <= start_i;
            if (mul_load) begin
                mul_pend_q <= 1'b1; // A new load wins over an old done.
            end else if (mul_done) begin
                mul_pend_q <= 1'b0;
            end
        end
    end

    assign start_acc = start_i & ~start_q; // Rising edge only.
    assign is_div    = funct3_i[2];
    assign special   = div_zero | div_ovf;  // div_ovf is already signed-only.

    // REM after DIV, or REMU after DIVU, on the same operands.
    assign reuse = (((funct3_i == rv_m_pkg::REM)  && (prev_f3_q == rv_m_pkg::DIV)) ||
                    ((funct3_i == rv_m_pkg::REMU) && (prev_f3_q == rv_m_pkg::DIVU)))
                 && (rs1_i == prev_a_q) && (rs2_i == prev_b_q);

    assign mul_load  = start_acc & ~is_div;
    assign div_start = start_acc & is_div & ~special & ~reuse;

    // Start cycle, then multiplier or divider in flight.
    assign busy_o = mul_load | div_start | (mul_pend_q & ~mul_done) | div_busy;

    // ****************************************
    // Remainder reuse history.
    // ****************************************
    // A reuse leaves the history as it was, so REM can repeat.
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            prev_a_q  <= '0;
            prev_b_q  <= '0;
            prev_f3_q <= rv_m_pkg::MUL;
        end else if (start_acc && !reuse) begin
            prev_a_q  <= rs1_i;
            prev_b_q  <= rs2_i;
            prev_f3_q <= funct3_i;
        end
    end

    // ****************************************
    // Sign correction and result select.
    // ****************************************
    always_comb begin
        if (div_zero) begin
            q_res = '1;     // x/0 gives all ones.
        end else if (div_ovf) begin
            q_res = rs1_i;  // -2^31 / -1 wraps to -2^31.
        end else if (a_signed && b_signed &&
                     (rs1_i[rv_m_pkg::DATA_WIDTH-1] ^ rs2_i[rv_m_pkg::DATA_WIDTH-1])) begin
            q_res = ~quotient + 1'b1;
        end else begin
            q_res = quotient;
        end

        if (div_zero) begin
            r_res = rs1_i;  // Remainder of x/0 is the dividend.
        end else if (div_ovf) begin
            r_res = '0;
        end else if (a_signed && rs1_i[rv_m_pkg::DATA_WIDTH-1]) begin
            r_res = ~remainder + 1'b1; // Sign follows the dividend.
        end else begin
            r_res = remainder;
        end
    end

    always_comb begin
        case (funct3_i)
            rv_m_pkg::MUL:                   c_o = product[rv_m_pkg::DATA_WIDTH-1:0];
            rv_m_pkg::DIV, rv_m_pkg::DIVU:   c_o = q_res;
            rv_m_pkg::REM, rv_m_pkg::REMU:   c_o = r_res;
            default: c_o = product[2*rv_m_pkg::DATA_WIDTH-1:rv_m_pkg::DATA_WIDTH]; // MULH forms.
        endcase
    end

    // No operation is accepted while a product or a quotient is still on its way.
    a_no_start_in_flight : assert property (@(posedge clk) disable iff (!rstLow)
        start_acc |-> !(mul_pend_q && !mul_done) && !div_busy)
        else $error("muldiv_unit: start accepted while an operation is in flight");

endmodule

// File: logic/div_restoring.sv
// Iterative unsigned restoring divider, one quotient bit per cycle.
// Operands are magnitudes; sign handling and x/0 belong to the caller.
// Outputs hold their value after busy falls until the next start.
`timescale 1ns/1ns

module div_restoring (
    input  logic                            clk,
    input  logic                            rstLow,
    input  logic                            start_i,     // One-cycle start pulse.
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] dividend_i,
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] divisor_i,
    output logic [rv_m_pkg::DATA_WIDTH-1:0] quotient_o,
    output logic [rv_m_pkg::DATA_WIDTH-1:0] remainder_o,
    output logic                            busy_o       // High while stepping.
);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    typedef logic [muldiv_cfg_pkg::DIV_CNT_W-1:0] cnt_t;

    state_e                          state_q;
    cnt_t                            cnt_q;     // Steps still to go.
    logic [rv_m_pkg::DATA_WIDTH-1:0] rem_q;     // Partial remainder.
    logic [rv_m_pkg::DATA_WIDTH-1:0] quot_q;    // Dividend bits out, quotient bits in.
    logic [rv_m_pkg::DATA_WIDTH-1:0] divisor_q; // Latched divisor.
    logic [rv_m_pkg::DATA_WIDTH:0]   trial;     // Remainder with next dividend bit.
    logic [rv_m_pkg::DATA_WIDTH:0]   diff;      // Trial minus divisor.

    // ****************************************
    // Control FSM.
    // ****************************************
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        cnt_q   <= cnt_t'(rv_m_pkg::DATA_WIDTH); // One step per bit.
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == cnt_t'(1)) begin
                        state_q <= IDLE; // Last step done on this edge.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ****************************************
    // Datapath.
    // ****************************************
    assign trial = {rem_q, quot_q[rv_m_pkg::DATA_WIDTH-1]};
    assign diff  = trial - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (start_i && (state_q == IDLE)) begin
            rem_q     <= '0;
            quot_q    <= dividend_i;
            divisor_q <= divisor_i;
        end else if (state_q == RUN) begin
            if (!diff[rv_m_pkg::DATA_WIDTH]) begin
                rem_q  <= diff[rv_m_pkg::DATA_WIDTH-1:0]; // Divisor fits, keep difference.
                quot_q <= {quot_q[rv_m_pkg::DATA_WIDTH-2:0], 1'b1};
            end else begin
                rem_q  <= trial[rv_m_pkg::DATA_WIDTH-1:0]; // Restore.
                quot_q <= {quot_q[rv_m_pkg::DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign quotient_o  = quot_q;
    assign remainder_o = rem_q;
    assign busy_o      = (state_q == RUN);

    // The caller must wait for busy to fall before a new start.
    a_no_start_busy : assert property (@(posedge clk) disable iff (!rstLow)
        start_i |-> !busy_o)
        else $error("div_restoring: start while busy");

    // Busy from the edge after start for exactly DATA_WIDTH cycles.
    a_busy_length : assert property (@(posedge clk) disable iff (!rstLow)
        start_i |=> busy_o [*rv_m_pkg::DATA_WIDTH] ##1 !busy_o)
        else $error("div_restoring: wrong busy length");

endmodule

// File: logic/mul_pipe.sv
// Two-stage 33x33 multiplier covering signed, mixed and unsigned products.
// Product registers load only on a valid stage and hold until the next load.
`timescale 1ns/1ns

module mul_pipe (
    input  logic                              clk,
    input  logic                              rstLow,
    input  logic                              load_i,     // Capture operands this cycle.
    input  logic [rv_m_pkg::DATA_WIDTH-1:0]   a_i,        // Raw rs1.
    input  logic [rv_m_pkg::DATA_WIDTH-1:0]   b_i,        // Raw rs2.
    input  logic                              a_signed_i, // Sign-extend a.
    input  logic                              b_signed_i, // Sign-extend b.
    output logic [2*rv_m_pkg::DATA_WIDTH-1:0] product_o,  // Full 64-bit product.
    output logic                              done_o      // Product valid pulse.
);

    logic signed [rv_m_pkg::DATA_WIDTH:0]     a_ext_q;   // Stage one, 33 bits.
    logic signed [rv_m_pkg::DATA_WIDTH:0]     b_ext_q;
    logic signed [2*rv_m_pkg::DATA_WIDTH+1:0] prod_full; // 66-bit signed product.
    logic [muldiv_cfg_pkg::MUL_LATENCY-1:0]   load_sr;   // Load strobe per stage.

    // Stage one. The extra top bit makes every form a signed multiply.
    always_ff @(posedge clk) begin
        if (load_i) begin
            a_ext_q <= {a_signed_i & a_i[rv_m_pkg::DATA_WIDTH-1], a_i};
            b_ext_q <= {b_signed_i & b_i[rv_m_pkg::DATA_WIDTH-1], b_i};
        end
    end

    assign prod_full = a_ext_q * b_ext_q;

    // Stage two. Top two bits are pure sign copies.
    always_ff @(posedge clk) begin
        if (load_sr[0]) begin
            product_o <= prod_full[2*rv_m_pkg::DATA_WIDTH-1:0];
        end
    end

    // Strobe travels alongside the data.
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            load_sr <= '0;
        end else begin
            load_sr <= {load_sr[muldiv_cfg_pkg::MUL_LATENCY-2:0], load_i};
        end
    end

    assign done_o = load_sr[muldiv_cfg_pkg::MUL_LATENCY-1]; // Product now on product_o.

    // Every load produces its done exactly MUL_LATENCY cycles later.
    a_done_latency : assert property (@(posedge clk) disable iff (!rstLow)
        load_i |-> ##(muldiv_cfg_pkg::MUL_LATENCY) done_o)
        else $error("mul_pipe: done did not follow load");

endmodule

// File: logic/operand_prep.sv
// Operand decode for the MULDIV unit, purely combinational.
// The divide-by-zero flag is raised for any operation; the caller gates it.
`timescale 1ns/1ns

module operand_prep (
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] rs1_i,      // Multiplicand or dividend.
    input  logic [rv_m_pkg::DATA_WIDTH-1:0] rs2_i,      // Multiplier or divisor.
    input  rv_m_pkg::funct3_e               funct3_i,   // Operation select.
    output logic [rv_m_pkg::DATA_WIDTH-1:0] a_mag_o,    // Magnitude of rs1.
    output logic [rv_m_pkg::DATA_WIDTH-1:0] b_mag_o,    // Magnitude of rs2.
    output logic                            a_signed_o, // rs1 read as signed.
    output logic                            b_signed_o, // rs2 read as signed.
    output logic                            div_zero_o, // Divisor is zero.
    output logic                            div_ovf_o   // Signed overflow, -2^31 / -1.
);

    logic signed_div; // DIV or REM.
    logic a_neg;      // rs1 is a negative signed value.
    logic b_neg;      // rs2 is a negative signed value.

    // ****************************************
    // Signedness per operation.
    // ****************************************
    always_comb begin
        case (funct3_i)
            rv_m_pkg::MUL, rv_m_pkg::MULH, rv_m_pkg::DIV, rv_m_pkg::REM: begin
                a_signed_o = 1'b1;
                b_signed_o = 1'b1;
            end
            rv_m_pkg::MULHSU: begin
                a_signed_o = 1'b1; // Only rs1 carries a sign.
                b_signed_o = 1'b0;
            end
            default: begin
                a_signed_o = 1'b0; // MULHU, DIVU, REMU.
                b_signed_o = 1'b0;
            end
        endcase
    end

    assign signed_div = funct3_i[2] & ~funct3_i[0];

    // Two's complement magnitudes for the unsigned divider core.
    assign a_neg   = a_signed_o & rs1_i[rv_m_pkg::DATA_WIDTH-1];
    assign b_neg   = b_signed_o & rs2_i[rv_m_pkg::DATA_WIDTH-1];
    assign a_mag_o = a_neg ? (~rs1_i + 1'b1) : rs1_i;
    assign b_mag_o = b_neg ? (~rs2_i + 1'b1) : rs2_i;

    // Special cases answered without running the divider.
    assign div_zero_o = (rs2_i == '0);
    // Quotient 2^31 does not fit a signed word.
    assign div_ovf_o  = signed_div
                      & (rs1_i == {1'b1, {(rv_m_pkg::DATA_WIDTH-1){1'b0}}})
                      & (&rs2_i);

endmodule

// File: logic/muldiv_cfg_pkg.sv
// Micro-architecture constants of the MULDIV unit.
// MUL_LATENCY must match the two register stages built into mul_pipe.

package muldiv_cfg_pkg;

    // ****************************************
    // Multiplier.
    // ****************************************
    localparam int MUL_LATENCY = 2; // Register stages from load to product.

    // ****************************************
    // Divider.
    // ****************************************
    // Step counter must hold DATA_WIDTH itself, so 6 bits for 32.
    localparam int DIV_CNT_W = 6;

endpackage

// File: logic/rv_m_pkg.sv
// RV32 M-extension ISA definitions shared by the RTL and the testbench model.
// Only the 32-bit base width is covered; RV64 word forms are not defined here.

package rv_m_pkg;

    // ****************************************
    // Data path width.
    // ****************************************
    localparam int DATA_WIDTH = 32; // Operand and result width.

    // ****************************************
    // funct3 field of the MULDIV instructions.
    // ****************************************
    // Bit 2 set marks a division or remainder.
    // Bit 0 set marks the unsigned divide forms (DIVU, REMU).
    // For multiplies the low two bits pick which operands are signed.
    typedef enum logic [2:0] {
        MUL    = 3'b000, // Signed x signed, low word.
        MULH   = 3'b001, // Signed x signed, high word.
        MULHSU = 3'b010, // Signed rs1 x unsigned rs2, high word.
        MULHU  = 3'b011, // Unsigned x unsigned, high word.
        DIV    = 3'b100, // Signed quotient.
        DIVU   = 3'b101, // Unsigned quotient.
        REM    = 3'b110, // Signed remainder, sign of the dividend.
        REMU   = 3'b111  // Unsigned remainder.
    } funct3_e;

endpackage
